// File: hdl/ecal_dif_settings.svh
// ECAL DIF settings
// Opcodes, high-voltage frame constants, serial and DAC timing

`ifndef ECAL_DIF_SETTINGS_SVH
`define ECAL_DIF_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Host command opcodes, top nibble of the command word
////////////////////////////////////////////////////////////
`define OP_HV_DIGIT1    4'h1         // Digit 1, most significant
`define OP_HV_DIGIT2    4'h2
`define OP_HV_DIGIT3    4'h3
`define OP_HV_DIGIT4    4'h4         // Digit 4, least significant
`define OP_HV_SEND      4'h5         // Arg bit 0 is start(1) / stop(0)
`define OP_DAC_SET      4'h6         // Arg is the 12-bit DAC code

////////////////////////////////////////////////////////////
// High-voltage module frame
////////////////////////////////////////////////////////////
`define HV_PREFIX_START 24'h48_42_56 // "HBV"
`define HV_PREFIX_STOP  24'h48_4F_46 // "HOF"
`define HV_FRAME_BYTES  7            // Prefix plus four digits
`define HV_BAUD_DIV     16           // Clocks per serial bit

////////////////////////////////////////////////////////////
// TLV5618 calibration DAC
////////////////////////////////////////////////////////////
`define DAC_CTRL_CHN_A  4'b1000      // Write channel A, slow mode
`define DAC_SCLK_HALF   4            // Clocks per half SCLK period

`endif

// File: hdl/ecal_dif_pkg.sv
// ECAL DIF types
// Command words, high-voltage digits, serial bytes and DAC codes

package ecal_dif_pkg;

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	// Opcode in [15:12], argument in [11:0]
	typedef logic [15:0] cmd_word_t;

	typedef logic [3:0] opcode_t;         // Top nibble of a command

	////////////////////////////////////////////////////////////
	// High-voltage path
	////////////////////////////////////////////////////////////

	typedef logic [3:0] hv_digit_t;       // One hex digit

	// Element 0 is digit 1, sent first
	typedef hv_digit_t [0:3] hv_digits_t;

	typedef logic [7:0] ascii_t;          // One byte on the serial line

	////////////////////////////////////////////////////////////
	// Calibration DAC
	////////////////////////////////////////////////////////////

	typedef logic [11:0] dac_code_t;      // TLV5618 code

endpackage

// File: hdl/usb_cmd_decoder.sv
// Host command decoder
// Turns strobed 16-bit command words into HV digits, HV send and DAC writes

`timescale 1ns/1ps

`include "ecal_dif_settings.svh"

module usb_cmd_decoder (
	input  logic                    Clk_Out_2_All,
	input  logic                    rst_i,
	input  ecal_dif_pkg::cmd_word_t cmd_i,           // Host word
	input  logic                    cmd_en_i,        // One-cycle qualifier
	output ecal_dif_pkg::hv_digits_t hv_digits_o,    // Digit 1 first
	output logic                    hv_start_flag_o, // 1 start, 0 stop
	output logic                    hv_send_o,       // Frame request pulse
	output ecal_dif_pkg::dac_code_t dac_code_o,
	output logic                    dac_start_o      // DAC write pulse
);

	import ecal_dif_pkg::*;

	opcode_t      opcode;
	logic [11:0]  arg;
	hv_digit_t    arg_digit;

	// Field split
	assign opcode    = cmd_i[15:12];
	assign arg       = cmd_i[11:0];
	assign arg_digit = arg[3:0];      // Digit opcodes use the low nibble

	////////////////////////////////////////////////////////////
	// Settings and pulses, all registered
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			hv_digits_o     <= '0;
			hv_start_flag_o <= 1'b0;
			hv_send_o       <= 1'b0;
			dac_code_o      <= '0;
			dac_start_o     <= 1'b0;
		end
		else
		begin
			hv_send_o   <= 1'b0;      // Pulses last one cycle
			dac_start_o <= 1'b0;
			if (cmd_en_i)
			begin
				case (opcode)
					`OP_HV_DIGIT1: hv_digits_o[0] <= arg_digit;
					`OP_HV_DIGIT2: hv_digits_o[1] <= arg_digit;
					`OP_HV_DIGIT3: hv_digits_o[2] <= arg_digit;
					`OP_HV_DIGIT4: hv_digits_o[3] <= arg_digit;
					`OP_HV_SEND:
					begin
						hv_start_flag_o <= arg[0];  // Level, valid with the pulse
						hv_send_o       <= 1'b1;
					end
					`OP_DAC_SET:
					begin
						dac_code_o  <= arg;
						dac_start_o <= 1'b1;
					end
					default: ;                  // Unknown opcode, dropped
				endcase
			end
		end
	end

endmodule

// File: hdl/hv_cmd_builder.sv
// High-voltage frame builder
// Sends prefix "HBV"/"HOF" and four ASCII digits byte by byte to the UART

`timescale 1ns/1ps

`include "ecal_dif_settings.svh"

module hv_cmd_builder (
	input  logic                     Clk_Out_2_All,
	input  logic                     rst_i,
	input  ecal_dif_pkg::hv_digits_t hv_digits_i,
	input  logic                     hv_start_flag_i,
	input  logic                     hv_send_i,      // Frame request
	input  logic                     tx_busy_i,      // UART shifting
	output ecal_dif_pkg::ascii_t     tx_byte_o,
	output logic                     tx_start_o      // One pulse per byte
);

	import ecal_dif_pkg::*;

	logic        active;          // Frame in progress
	logic [2:0]  byte_idx;        // Next byte to hand over
	logic [23:0] prefix_q;        // Chosen three-letter prefix
	hv_digits_t  digits_q;        // Digits frozen at frame start
	ascii_t      next_byte;

	// Hex nibble to '0'-'9' / 'A'-'F'
	function automatic ascii_t hex_to_ascii(input hv_digit_t d);
		if (d < 4'd10)
			return 8'h30 + {4'h0, d};
		else
			return 8'h37 + {4'h0, d};   // 'A' is 0x41
	endfunction

	// Byte select
	always_comb
	begin
		case (byte_idx)
			3'd0:    next_byte = prefix_q[23:16];
			3'd1:    next_byte = prefix_q[15:8];
			3'd2:    next_byte = prefix_q[7:0];
			3'd3:    next_byte = hex_to_ascii(digits_q[0]);
			3'd4:    next_byte = hex_to_ascii(digits_q[1]);
			3'd5:    next_byte = hex_to_ascii(digits_q[2]);
			3'd6:    next_byte = hex_to_ascii(digits_q[3]);
			default: next_byte = 8'h00;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			active     <= 1'b0;
			byte_idx   <= '0;
			prefix_q   <= '0;
			digits_q   <= '0;
			tx_byte_o  <= '0;
			tx_start_o <= 1'b0;
		end
		else
		begin
			tx_start_o <= 1'b0;
			if (!active)
			begin
				if (hv_send_i)   // Requests during a frame never reach here
				begin
					active   <= 1'b1;
					byte_idx <= '0;
					digits_q <= hv_digits_i;
					prefix_q <= hv_start_flag_i ? `HV_PREFIX_START : `HV_PREFIX_STOP;
				end
			end
			else if (!tx_start_o && !tx_busy_i)  // UART idle, busy not yet seen
			begin
				if (byte_idx == 3'(`HV_FRAME_BYTES))
					active <= 1'b0;              // Last byte fully on the line
				else
				begin
					tx_start_o <= 1'b1;
					tx_byte_o  <= next_byte;
					byte_idx   <= byte_idx + 3'd1;
				end
			end
		end
	end

endmodule

// File: hdl/hv_uart_tx.sv
// Serial transmitter toward the high-voltage module
// 8N1, LSB first, line idles high

`timescale 1ns/1ps

`include "ecal_dif_settings.svh"

module hv_uart_tx (
	input  logic                 Clk_Out_2_All,
	input  logic                 rst_i,
	input  ecal_dif_pkg::ascii_t tx_byte_i,
	input  logic                 tx_start_i,
	output logic                 tx_busy_o,
	output logic                 hv_rx_o       // Serial line to HV module
);

	localparam int BAUD_DIV = `HV_BAUD_DIV;
	localparam int BAUD_W   = $clog2(BAUD_DIV);

	logic [BAUD_W-1:0] baud_cnt;   // Clocks within one bit
	logic [3:0]        bit_cnt;    // 0 start, 1..8 data, 9 stop
	logic [8:0]        shift_q;    // Remaining data bits plus stop bit

	////////////////////////////////////////////////////////////
	// Shift engine
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			tx_busy_o <= 1'b0;
			hv_rx_o   <= 1'b1;     // Idle high
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			shift_q   <= '1;
		end
		else if (!tx_busy_o)
		begin
			if (tx_start_i)
			begin
				tx_busy_o <= 1'b1;
				hv_rx_o   <= 1'b0;             // Start bit right away
				shift_q   <= {1'b1, tx_byte_i};
				baud_cnt  <= '0;
				bit_cnt   <= '0;
			end
		end
		else if (baud_cnt == BAUD_W'(BAUD_DIV - 1))
		begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9)
				tx_busy_o <= 1'b0;             // Stop bit done, line stays high
			else
			begin
				bit_cnt <= bit_cnt + 4'd1;
				hv_rx_o <= shift_q[0];         // LSB first
				shift_q <= {1'b1, shift_q[8:1]};
			end
		end
		else
			baud_cnt <= baud_cnt + BAUD_W'(1);
	end

endmodule

// File: hdl/dac_tlv5618_writer.sv
// TLV5618 calibration DAC writer
// Shifts control nibble and 12-bit code MSB first, sampled on SCLK fall

`timescale 1ns/1ps

`include "ecal_dif_settings.svh"

module dac_tlv5618_writer (
	input  logic                    Clk_Out_2_All,
	input  logic                    rst_i,
	input  ecal_dif_pkg::dac_code_t dac_code_i,
	input  logic                    dac_start_i,   // Write request pulse
	output logic                    dac_sclk_o,    // Idles high
	output logic                    dac_din_o,
	output logic                    dac_cs_n_o     // Low during the word
);

	localparam int HALF   = `DAC_SCLK_HALF;
	localparam int HALF_W = $clog2(HALF);

	logic [HALF_W-1:0] half_cnt;   // Clocks within one SCLK phase
	logic [3:0]        bit_cnt;    // Bits already started, 0..15
	logic [15:0]       shift_q;

	assign dac_din_o = shift_q[15];  // MSB on the pin

	////////////////////////////////////////////////////////////
	// SCLK divider and shifter, chip select doubles as busy
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (rst_i)
		begin
			dac_sclk_o <= 1'b1;
			dac_cs_n_o <= 1'b1;
			half_cnt   <= '0;
			bit_cnt    <= '0;
			shift_q    <= '0;
		end
		else if (dac_cs_n_o)
		begin
			if (dac_start_i)
			begin
				dac_cs_n_o <= 1'b0;
				shift_q    <= {`DAC_CTRL_CHN_A, dac_code_i};
				half_cnt   <= '0;
				bit_cnt    <= '0;
			end
		end
		else if (half_cnt == HALF_W'(HALF - 1))
		begin
			half_cnt <= '0;
			if (dac_sclk_o)
				dac_sclk_o <= 1'b0;                // DAC samples here
			else
			begin
				dac_sclk_o <= 1'b1;
				if (bit_cnt == 4'd15)
					dac_cs_n_o <= 1'b1;            // Word complete
				else
				begin
					bit_cnt <= bit_cnt + 4'd1;
					shift_q <= {shift_q[14:0], 1'b0};  // Next bit while SCLK high
				end
			end
		end
		else
			half_cnt <= half_cnt + HALF_W'(1);
	end

endmodule

// File: hdl/ecal_dif_top.sv
// ECAL DIF top level
// Command decoder feeding the HV serial path and the calibration DAC writer

`timescale 1ns/1ps

module ecal_dif_top (
	input  logic                    Clk_Out_2_All,
	input  logic                    rst_i,
	input  ecal_dif_pkg::cmd_word_t cmd_i,
	input  logic                    cmd_en_i,
	output logic                    hv_rx_o,      // To HV module
	output logic                    dac_sclk_o,
	output logic                    dac_din_o,
	output logic                    dac_cs_n_o
);

	import ecal_dif_pkg::*;

	hv_digits_t hv_digits;
	logic       hv_start_flag;
	logic       hv_send;
	dac_code_t  dac_code;
	logic       dac_start;
	ascii_t     tx_byte;
	logic       tx_start;
	logic       tx_busy;

	usb_cmd_decoder u_decoder (
		.Clk_Out_2_All   (Clk_Out_2_All),
		.rst_i           (rst_i),
		.cmd_i           (cmd_i),
		.cmd_en_i        (cmd_en_i),
		.hv_digits_o     (hv_digits),
		.hv_start_flag_o (hv_start_flag),
		.hv_send_o       (hv_send),
		.dac_code_o      (dac_code),
		.dac_start_o     (dac_start)
	);

	// HV path
	hv_cmd_builder u_hv_builder (
		.Clk_Out_2_All   (Clk_Out_2_All),
		.rst_i           (rst_i),
		.hv_digits_i     (hv_digits),
		.hv_start_flag_i (hv_start_flag),
		.hv_send_i       (hv_send),
		.tx_busy_i       (tx_busy),
		.tx_byte_o       (tx_byte),
		.tx_start_o      (tx_start)
	);

	hv_uart_tx u_hv_uart (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.tx_byte_i     (tx_byte),
		.tx_start_i    (tx_start),
		.tx_busy_o     (tx_busy),
		.hv_rx_o       (hv_rx_o)
	);

	// Calibration DAC, channel A
	dac_tlv5618_writer u_dac (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst_i),
		.dac_code_i    (dac_code),
		.dac_start_i   (dac_start),
		.dac_sclk_o    (dac_sclk_o),
		.dac_din_o     (dac_din_o),
		.dac_cs_n_o    (dac_cs_n_o)
	);

endmodule

// File: testbench/tb_ecal_dif.sv
// ECAL DIF testbench
// Drives host commands and checks HV serial frames and DAC words

`timescale 1ns/1ps

`include "ecal_dif_settings.svh"

module tb_ecal_dif;

	import ecal_dif_pkg::*;

	localparam int BAUD   = `HV_BAUD_DIV;
	localparam int NBYTES = `HV_FRAME_BYTES;

	logic       Clk_Out_2_All = 1'b0;
	logic       rst;
	cmd_word_t  cmd;
	logic       cmd_en;
	logic       hv_rx;
	logic       dac_sclk;
	logic       dac_din;
	logic       dac_cs_n;

	int          err_cnt   = 0;      // Failed value checks
	int          tout_cnt  = 0;      // Waits that ran out
	logic [15:0] lfsr_q    = 16'd14; // LFSR state
	ascii_t      rx_q[$];            // Bytes seen on the HV line
	logic        dac_q[$];           // Bits seen by the DAC model
	hv_digits_t  digits;             // Digits last written to the decoder
	int          rx_clk;             // Clocks since start bit seen
	logic        rx_on     = 1'b0;
	logic [9:0]  rx_bits;            // Start, 8 data LSB first, stop
	logic        sclk_prev = 1'b1;

	ecal_dif_top dut (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_i         (rst),
		.cmd_i         (cmd),
		.cmd_en_i      (cmd_en),
		.hv_rx_o       (hv_rx),
		.dac_sclk_o    (dac_sclk),
		.dac_din_o     (dac_din),
		.dac_cs_n_o    (dac_cs_n)
	);

	always #2 Clk_Out_2_All = ~Clk_Out_2_All;   // 4 ns period

	// Galois LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			r      = {r[14:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return r;
	endfunction

	// Expected ASCII of one hex digit
	function automatic ascii_t hex_char(input logic [3:0] d);
		if (d > 4'd9)
			return 8'h41 + 8'(d - 4'd10);   // 'A'..'F'
		return 8'h30 + 8'(d);               // '0'..'9'
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok)
		else
		begin
			err_cnt++;
			$display("FAIL %0t: %s", $time, msg);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Receive models
	////////////////////////////////////////////////////////////

	// HV serial line sampled mid-bit
	always @(posedge Clk_Out_2_All)
	begin
		if (rst)
			rx_on = 1'b0;
		else if (!rx_on)
		begin
			if (!hv_rx)
			begin
				rx_on  = 1'b1;              // Falling edge of start bit
				rx_clk = 0;
			end
		end
		else
		begin
			rx_clk++;
			if (rx_clk % BAUD == BAUD / 2 - 1)
			begin
				rx_bits[rx_clk / BAUD] = hv_rx;
				if (rx_clk / BAUD == 9)
				begin
					check(rx_bits[0] == 1'b0 && rx_bits[9] == 1'b1,
						$sformatf("bad start/stop bit on byte %0d", rx_q.size()));
					rx_q.push_back(rx_bits[8:1]);
					rx_on = 1'b0;
				end
			end
		end
	end

	// DAC model takes DIN on SCLK fall while CS low
	always @(posedge Clk_Out_2_All)
	begin
		if (!rst && sclk_prev && !dac_sclk && !dac_cs_n)
			dac_q.push_back(dac_din);
		sclk_prev = dac_sclk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus and waits
	////////////////////////////////////////////////////////////
	task automatic drive_cmd(input logic [3:0] op, input logic [11:0] arg);
		@(posedge Clk_Out_2_All);
		#1;
		cmd    = {op, arg};
		cmd_en = 1'b1;                  // Single-cycle strobe
		@(posedge Clk_Out_2_All);
		#1;
		cmd_en = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge Clk_Out_2_All);
		#1;
	endtask

	task automatic wait_bytes(input int n);
		int t;
		t = 0;
		while (rx_q.size() < n && t < 4000)
		begin
			@(posedge Clk_Out_2_All);
			#1;
			t++;
		end
		if (rx_q.size() < n)
		begin
			tout_cnt++;
			$display("Timeout: only %0d of %0d bytes arrived on the HV line",
				rx_q.size(), n);
		end
	endtask

	task automatic wait_cs(input logic level);
		int t;
		t = 0;
		while (dac_cs_n !== level && t < 500)
		begin
			@(posedge Clk_Out_2_All);
			#1;
			t++;
		end
		if (dac_cs_n !== level)
		begin
			tout_cnt++;
			$display("Timeout: DAC chip select never went to %0b", level);
		end
	endtask

	// Full frame then room for a stray extra byte
	task automatic expect_frame(input logic [23:0] prefix);
		ascii_t exp_byte;
		int     i;
		wait_bytes(NBYTES);
		idle_cycles(16 * BAUD);
		check(rx_q.size() == NBYTES, $sformatf("frame has %0d bytes", rx_q.size()));
		for (i = 0; i < NBYTES && i < rx_q.size(); i++)
		begin
			exp_byte = (i < 3) ? prefix[23 - 8 * i -: 8] : hex_char(digits[i - 3]);
			check(rx_q[i] == exp_byte,
				$sformatf("byte %0d is %h, expected %h", i, rx_q[i], exp_byte));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int          i;
		dac_code_t   code;
		logic [15:0] word;
		rst    = 1'b1;
		cmd    = '0;
		cmd_en = 1'b0;
		digits = '0;
		repeat (4) @(posedge Clk_Out_2_All);
		#1;
		rst = 1'b0;

		// Idle levels and nothing sent on its own
		check(hv_rx === 1'b1 && dac_cs_n === 1'b1 && dac_sclk === 1'b1,
			"outputs not idle after reset");
		idle_cycles(200);
		check(rx_q.size() == 0 && dac_q.size() == 0, "activity after reset");

		// Start frame with digit 3 forced into A-F
		for (i = 0; i < 4; i++)
		begin
			digits[i] = (i == 2) ? 4'(4'hA + rand_bits(4) % 6) : 4'(rand_bits(4));
			drive_cmd(4'(`OP_HV_DIGIT1 + i), {8'(rand_bits(8)), digits[i]});
		end
		rx_q.delete();
		drive_cmd(`OP_HV_SEND, 12'h001);
		expect_frame(`HV_PREFIX_START);

		// Stop frame with a second send mid-frame
		rx_q.delete();
		drive_cmd(`OP_HV_SEND, 12'h000);
		wait_bytes(2);
		drive_cmd(`OP_HV_SEND, 12'h001);   // Dropped while the builder is busy
		expect_frame(`HV_PREFIX_STOP);

		// DAC write with a second write while CS low
		dac_q.delete();
		code = 12'(rand_bits(12));
		drive_cmd(`OP_DAC_SET, code);
		wait_cs(1'b0);
		drive_cmd(`OP_DAC_SET, ~code);
		wait_cs(1'b1);
		idle_cycles(40);
		check(dac_q.size() == 16, $sformatf("DAC got %0d bits", dac_q.size()));
		word = '0;
		for (i = 0; i < 16 && i < dac_q.size(); i++)
			word = {word[14:0], dac_q[i]};  // MSB first
		check(word == {`DAC_CTRL_CHN_A, code},
			$sformatf("DAC word %h, expected %h", word, {`DAC_CTRL_CHN_A, code}));
		check(dac_cs_n === 1'b1, "DAC chip select low after the word");

		// Opcodes 0 and 15 do nothing
		rx_q.delete();
		dac_q.delete();
		drive_cmd(4'h0, 12'(rand_bits(12)));
		drive_cmd(4'hF, 12'hFFF);
		idle_cycles(16 * BAUD);
		check(rx_q.size() == 0 && dac_q.size() == 0 && dac_cs_n === 1'b1,
			"activity after an unknown opcode");
		drive_cmd(`OP_HV_SEND, 12'h001);   // Digits must be untouched
		expect_frame(`HV_PREFIX_START);

		$display("Errors: %0d value checks, %0d timeouts", err_cnt, tout_cnt);
		if (err_cnt == 0 && tout_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+hdl
hdl/ecal_dif_pkg.sv
hdl/usb_cmd_decoder.sv
hdl/hv_cmd_builder.sv
hdl/hv_uart_tx.sv
hdl/dac_tlv5618_writer.sv
hdl/ecal_dif_top.sv
testbench/tb_ecal_dif.sv

// File: Bender.yml
package:
  name: ecal_dif

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ecal_dif_pkg.sv
      - hdl/usb_cmd_decoder.sv
      - hdl/hv_cmd_builder.sv
      - hdl/hv_uart_tx.sv
      - hdl/dac_tlv5618_writer.sv
      - hdl/ecal_dif_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_ecal_dif.sv
